//--- include/rv_opcodes.svh
/*
 * RV32IMA encoding constants
 * major opcodes, funct3 and funct7 values, AMO funct5
 * fixed SYSTEM words (ecall, sret, mret)
 */
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// major opcodes
localparam logic [6:0] OPC_LOAD    = 7'b0000011;
localparam logic [6:0] OPC_STORE   = 7'b0100011;
localparam logic [6:0] OPC_OP      = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
localparam logic [6:0] OPC_JAL     = 7'b1101111;
localparam logic [6:0] OPC_JALR    = 7'b1100111;
localparam logic [6:0] OPC_LUI     = 7'b0110111;
localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;
localparam logic [6:0] OPC_AMO     = 7'b0101111;

// load / store / amo widths
localparam logic [2:0] F3_B   = 3'b000;
localparam logic [2:0] F3_H   = 3'b001;
localparam logic [2:0] F3_W   = 3'b010;
localparam logic [2:0] F3_BU  = 3'b100;
localparam logic [2:0] F3_HU  = 3'b101;

// integer alu, shared by OP and OP-IMM
localparam logic [2:0] F3_ADD  = 3'b000;   // also sub
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;   // srl / sra
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;

// branches
localparam logic [2:0] F3_BEQ  = 3'b000;
localparam logic [2:0] F3_BNE  = 3'b001;
localparam logic [2:0] F3_BLT  = 3'b100;
localparam logic [2:0] F3_BGE  = 3'b101;
localparam logic [2:0] F3_BLTU = 3'b110;
localparam logic [2:0] F3_BGEU = 3'b111;

localparam logic [2:0] F3_JALR = 3'b000;

// csr access
localparam logic [2:0] F3_CSRRW  = 3'b001;
localparam logic [2:0] F3_CSRRS  = 3'b010;
localparam logic [2:0] F3_CSRRC  = 3'b011;
localparam logic [2:0] F3_CSRRWI = 3'b101;
localparam logic [2:0] F3_CSRRSI = 3'b110;
localparam logic [2:0] F3_CSRRCI = 3'b111;

// RV32M
localparam logic [2:0] F3_MUL    = 3'b000;
localparam logic [2:0] F3_MULH   = 3'b001;
localparam logic [2:0] F3_MULHSU = 3'b010;
localparam logic [2:0] F3_MULHU  = 3'b011;
localparam logic [2:0] F3_DIV    = 3'b100;
localparam logic [2:0] F3_DIVU   = 3'b101;
localparam logic [2:0] F3_REM    = 3'b110;
localparam logic [2:0] F3_REMU   = 3'b111;

localparam logic [6:0] F7_BASE    = 7'b0000000;
localparam logic [6:0] F7_ALT     = 7'b0100000;   // sub, sra, srai
localparam logic [6:0] F7_MULDIV  = 7'b0000001;
localparam logic [4:0] F5_AMOSWAP = 5'b00001;

// whole-word SYSTEM encodings
localparam logic [31:0] INST_ECALL = 32'h00000073;
localparam logic [31:0] INST_SRET  = 32'h10200073;
localparam logic [31:0] INST_MRET  = 32'h30200073;

`endif

//--- src/core_pkg.sv
/*
 * core types for decode and operand issue
 * word, register index and tag types
 * control enums: alu, operand selects, memory, write-back, csr
 * fetch, control and issue bundles, decoder helper structs
 */
package core_pkg;

`include "rv_opcodes.svh"

typedef logic [31:0] xlen_t;
typedef logic [4:0]  reg_idx_t;
typedef logic [63:0] inst_id_t;   // opaque tag from fetch

typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_JALR,
    ALU_COPY1,                                    // pass op1 through
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
} alu_fn_e;

typedef enum logic [3:0] {
    OP1_NONE = 4'd0,
    OP1_RS1  = 4'd1,
    OP1_PC   = 4'd2,
    OP1_IMZ  = 4'd3    // csr immediate, zero-extended
} op1_sel_e;

typedef enum logic [3:0] {
    OP2_NONE = 4'd0,
    OP2_RS2  = 4'd1,
    OP2_IMI  = 4'd2,
    OP2_IMS  = 4'd3,
    OP2_IMJ  = 4'd4,
    OP2_IMU  = 4'd5
} op2_sel_e;

typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
    MEM_SB, MEM_SH, MEM_SW,
    MEM_AMOSWAP
} mem_fn_e;

typedef enum logic [3:0] {
    WB_NONE, WB_ALU, WB_PC, WB_CSR,
    WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW
} wb_sel_e;

typedef enum logic [2:0] {
    CSR_NONE, CSR_W, CSR_S, CSR_C,
    CSR_ECALL, CSR_SRET, CSR_MRET
} csr_cmd_e;

typedef struct packed {
    xlen_t    pc;
    xlen_t    inst;
    inst_id_t inst_id;
} fetch_t;

typedef struct packed {
    alu_fn_e  alu_fn;
    op1_sel_e op1_sel;
    op2_sel_e op2_sel;
    mem_fn_e  mem_fn;
    logic     rf_wen;
    wb_sel_e  wb_sel;
    reg_idx_t wb_addr;
    csr_cmd_e csr_cmd;
    logic     jmp_pc;     // jal
    logic     jmp_reg;    // jalr
    logic     br_flg;
    xlen_t    imm_b;      // sign-extended branch offset
} ctrl_t;

typedef struct packed {
    xlen_t    pc;
    inst_id_t inst_id;
    ctrl_t    ctrl;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    rs2_data;   // store / amo data
} issue_t;

// base field split of an instruction word
typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
} inst_fields_t;

// what one line of the opcode table sets
typedef struct packed {
    alu_fn_e  alu_fn;
    op1_sel_e op1_sel;
    op2_sel_e op2_sel;
    mem_fn_e  mem_fn;
    logic     rf_wen;
    wb_sel_e  wb_sel;
    csr_cmd_e csr_cmd;
    logic     br_flg;
} dec_row_t;

endpackage

//--- src/inst_decoder.sv
/*
 * instruction decoder
 * priority wildcard table for RV32I, RV32M and AMOSWAP.W
 * jump marks, rd index, source indices and branch immediate
 */
`timescale 1ns/100ps

module inst_decoder
    import core_pkg::*;
(
    input  xlen_t    inst,
    output ctrl_t    ctrl,
    output reg_idx_t rs1,
    output reg_idx_t rs2
);

    inst_fields_t f;
    dec_row_t     row;

    function automatic dec_row_t mk(alu_fn_e fn, op1_sel_e o1, op2_sel_e o2,
                                    mem_fn_e mem, logic wen, wb_sel_e wb,
                                    csr_cmd_e csr, logic br);
        return '{alu_fn: fn, op1_sel: o1, op2_sel: o2, mem_fn: mem,
                 rf_wen: wen, wb_sel: wb, csr_cmd: csr, br_flg: br};
    endfunction

    // reg-reg and reg-imm alu ops
    function automatic dec_row_t rr_row(alu_fn_e fn);
        return mk(fn, OP1_RS1, OP2_RS2, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
    endfunction

    function automatic dec_row_t ri_row(alu_fn_e fn);
        return mk(fn, OP1_RS1, OP2_IMI, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
    endfunction

    function automatic dec_row_t ld_row(mem_fn_e mem, wb_sel_e wb);
        return mk(ALU_ADD, OP1_RS1, OP2_IMI, mem, 1'b1, wb, CSR_NONE, 1'b0);
    endfunction

    function automatic dec_row_t st_row(mem_fn_e mem);
        return mk(ALU_ADD, OP1_RS1, OP2_IMS, mem, 1'b0, WB_NONE, CSR_NONE, 1'b0);
    endfunction

    function automatic dec_row_t br_row(alu_fn_e fn);
        return mk(fn, OP1_RS1, OP2_RS2, MEM_NONE, 1'b0, WB_NONE, CSR_NONE, 1'b1);
    endfunction

    function automatic dec_row_t csr_row(op1_sel_e o1, csr_cmd_e cmd);
        return mk(ALU_COPY1, o1, OP2_NONE, MEM_NONE, 1'b1, WB_CSR, cmd, 1'b0);
    endfunction

    // ecall / sret / mret, also the nop when cmd is none
    function automatic dec_row_t sys_row(csr_cmd_e cmd);
        return mk(ALU_ADD, OP1_NONE, OP2_NONE, MEM_NONE, 1'b0, WB_NONE, cmd, 1'b0);
    endfunction

    always_comb begin
        casez (inst)
            {17'b?, F3_B,  5'b?, OPC_LOAD}:  row = ld_row(MEM_LB,  WB_MEMB);
            {17'b?, F3_BU, 5'b?, OPC_LOAD}:  row = ld_row(MEM_LBU, WB_MEMBU);
            {17'b?, F3_H,  5'b?, OPC_LOAD}:  row = ld_row(MEM_LH,  WB_MEMH);
            {17'b?, F3_HU, 5'b?, OPC_LOAD}:  row = ld_row(MEM_LHU, WB_MEMHU);
            {17'b?, F3_W,  5'b?, OPC_LOAD}:  row = ld_row(MEM_LW,  WB_MEMW);
            {17'b?, F3_B,  5'b?, OPC_STORE}: row = st_row(MEM_SB);
            {17'b?, F3_H,  5'b?, OPC_STORE}: row = st_row(MEM_SH);
            {17'b?, F3_W,  5'b?, OPC_STORE}: row = st_row(MEM_SW);

            {F7_BASE, 10'b?, F3_ADD,  5'b?, OPC_OP}: row = rr_row(ALU_ADD);
            {F7_ALT,  10'b?, F3_ADD,  5'b?, OPC_OP}: row = rr_row(ALU_SUB);
            {F7_BASE, 10'b?, F3_AND,  5'b?, OPC_OP}: row = rr_row(ALU_AND);
            {F7_BASE, 10'b?, F3_OR,   5'b?, OPC_OP}: row = rr_row(ALU_OR);
            {F7_BASE, 10'b?, F3_XOR,  5'b?, OPC_OP}: row = rr_row(ALU_XOR);
            {F7_BASE, 10'b?, F3_SLL,  5'b?, OPC_OP}: row = rr_row(ALU_SLL);
            {F7_BASE, 10'b?, F3_SR,   5'b?, OPC_OP}: row = rr_row(ALU_SRL);
            {F7_ALT,  10'b?, F3_SR,   5'b?, OPC_OP}: row = rr_row(ALU_SRA);
            {F7_BASE, 10'b?, F3_SLT,  5'b?, OPC_OP}: row = rr_row(ALU_SLT);
            {F7_BASE, 10'b?, F3_SLTU, 5'b?, OPC_OP}: row = rr_row(ALU_SLTU);

            {17'b?, F3_ADD,  5'b?, OPC_OP_IMM}: row = ri_row(ALU_ADD);
            {17'b?, F3_AND,  5'b?, OPC_OP_IMM}: row = ri_row(ALU_AND);
            {17'b?, F3_OR,   5'b?, OPC_OP_IMM}: row = ri_row(ALU_OR);
            {17'b?, F3_XOR,  5'b?, OPC_OP_IMM}: row = ri_row(ALU_XOR);
            {17'b?, F3_SLT,  5'b?, OPC_OP_IMM}: row = ri_row(ALU_SLT);
            {17'b?, F3_SLTU, 5'b?, OPC_OP_IMM}: row = ri_row(ALU_SLTU);
            {F7_BASE, 10'b?, F3_SLL, 5'b?, OPC_OP_IMM}: row = ri_row(ALU_SLL);
            {F7_BASE, 10'b?, F3_SR,  5'b?, OPC_OP_IMM}: row = ri_row(ALU_SRL);
            {F7_ALT,  10'b?, F3_SR,  5'b?, OPC_OP_IMM}: row = ri_row(ALU_SRA);

            {17'b?, F3_BEQ,  5'b?, OPC_BRANCH}: row = br_row(ALU_BEQ);
            {17'b?, F3_BNE,  5'b?, OPC_BRANCH}: row = br_row(ALU_BNE);
            {17'b?, F3_BLT,  5'b?, OPC_BRANCH}: row = br_row(ALU_BLT);
            {17'b?, F3_BGE,  5'b?, OPC_BRANCH}: row = br_row(ALU_BGE);
            {17'b?, F3_BLTU, 5'b?, OPC_BRANCH}: row = br_row(ALU_BLTU);
            {17'b?, F3_BGEU, 5'b?, OPC_BRANCH}: row = br_row(ALU_BGEU);

            {25'b?, OPC_JAL}:
                row = mk(ALU_ADD, OP1_PC, OP2_IMJ, MEM_NONE, 1'b1, WB_PC, CSR_NONE, 1'b0);
            {17'b?, F3_JALR, 5'b?, OPC_JALR}:
                row = mk(ALU_JALR, OP1_RS1, OP2_IMI, MEM_NONE, 1'b1, WB_PC, CSR_NONE, 1'b0);
            {25'b?, OPC_LUI}:
                row = mk(ALU_ADD, OP1_NONE, OP2_IMU, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
            {25'b?, OPC_AUIPC}:
                row = mk(ALU_ADD, OP1_PC, OP2_IMU, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);

            {17'b?, F3_CSRRW,  5'b?, OPC_SYSTEM}: row = csr_row(OP1_RS1, CSR_W);
            {17'b?, F3_CSRRWI, 5'b?, OPC_SYSTEM}: row = csr_row(OP1_IMZ, CSR_W);
            {17'b?, F3_CSRRS,  5'b?, OPC_SYSTEM}: row = csr_row(OP1_RS1, CSR_S);
            {17'b?, F3_CSRRSI, 5'b?, OPC_SYSTEM}: row = csr_row(OP1_IMZ, CSR_S);
            {17'b?, F3_CSRRC,  5'b?, OPC_SYSTEM}: row = csr_row(OP1_RS1, CSR_C);
            {17'b?, F3_CSRRCI, 5'b?, OPC_SYSTEM}: row = csr_row(OP1_IMZ, CSR_C);
            INST_ECALL: row = sys_row(CSR_ECALL);
            INST_SRET:  row = sys_row(CSR_SRET);
            INST_MRET:  row = sys_row(CSR_MRET);

            {F7_MULDIV, 10'b?, F3_MUL,    5'b?, OPC_OP}: row = rr_row(ALU_MUL);
            {F7_MULDIV, 10'b?, F3_MULH,   5'b?, OPC_OP}: row = rr_row(ALU_MULH);
            {F7_MULDIV, 10'b?, F3_MULHSU, 5'b?, OPC_OP}: row = rr_row(ALU_MULHSU);
            {F7_MULDIV, 10'b?, F3_MULHU,  5'b?, OPC_OP}: row = rr_row(ALU_MULHU);
            {F7_MULDIV, 10'b?, F3_DIV,    5'b?, OPC_OP}: row = rr_row(ALU_DIV);
            {F7_MULDIV, 10'b?, F3_DIVU,   5'b?, OPC_OP}: row = rr_row(ALU_DIVU);
            {F7_MULDIV, 10'b?, F3_REM,    5'b?, OPC_OP}: row = rr_row(ALU_REM);
            {F7_MULDIV, 10'b?, F3_REMU,   5'b?, OPC_OP}: row = rr_row(ALU_REMU);

            // aq/rl bits ignored
            {F5_AMOSWAP, 12'b?, F3_W, 5'b?, OPC_AMO}:
                row = mk(ALU_COPY1, OP1_RS1, OP2_NONE, MEM_AMOSWAP, 1'b1, WB_MEMW,
                         CSR_NONE, 1'b0);

            default: row = sys_row(CSR_NONE);   // nop
        endcase
    end

    assign f   = inst;
    assign rs1 = f.rs1;
    assign rs2 = f.rs2;

    always_comb begin
        ctrl.alu_fn  = row.alu_fn;
        ctrl.op1_sel = row.op1_sel;
        ctrl.op2_sel = row.op2_sel;
        ctrl.mem_fn  = row.mem_fn;
        ctrl.rf_wen  = row.rf_wen;
        ctrl.wb_sel  = row.wb_sel;
        ctrl.wb_addr = f.rd;
        ctrl.csr_cmd = row.csr_cmd;
        ctrl.jmp_pc  = f.opcode == OPC_JAL;
        ctrl.jmp_reg = (f.opcode == OPC_JALR) && (f.funct3 == F3_JALR);
        ctrl.br_flg  = row.br_flg;
        ctrl.imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end

endmodule

//--- src/reg_file.sv
/*
 * integer register file
 * 32 x 32 bits, two async read ports, one sync write port
 * x0 reads as zero
 */
`timescale 1ns/100ps

module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t raddr1,
    output xlen_t    rdata1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata2,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  xlen_t    wdata
);

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 never written, so force its read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- src/operand_stage.sv
/*
 * operand stage
 * write-back forwarding, immediate build, op1/op2 select
 * issue output register
 */
`timescale 1ns/100ps

module operand_stage
    import core_pkg::*;
#(
    parameter bit FORWARD = 1'b1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dec_valid,
    input  fetch_t   dec_fetch,
    input  ctrl_t    ctrl,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  xlen_t    rdata1,
    input  xlen_t    rdata2,
    input  logic     wb_en,
    input  reg_idx_t wb_addr,
    input  xlen_t    wb_data,
    output logic     issue_valid,
    output issue_t   issue
);

    xlen_t iw;
    logic  fwd1;
    logic  fwd2;
    xlen_t src1;
    xlen_t src2;
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_j;
    xlen_t imm_u;
    xlen_t imm_z;
    xlen_t op1;
    xlen_t op2;

    // write-back landing at the edge that ends this cycle
    assign fwd1 = FORWARD && wb_en && (wb_addr == rs1) && (rs1 != '0);
    assign fwd2 = FORWARD && wb_en && (wb_addr == rs2) && (rs2 != '0);
    assign src1 = fwd1 ? wb_data : rdata1;
    assign src2 = fwd2 ? wb_data : rdata2;

    assign iw    = dec_fetch.inst;
    assign imm_i = {{20{iw[31]}}, iw[31:20]};
    assign imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    assign imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
    assign imm_u = {iw[31:12], 12'b0};
    assign imm_z = {27'b0, rs1};   // csr uimm sits in the rs1 field

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1 = src1;
            OP1_PC:  op1 = dec_fetch.pc;
            OP1_IMZ: op1 = imm_z;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2: op2 = src2;
            OP2_IMI: op2 = imm_i;
            OP2_IMS: op2 = imm_s;
            OP2_IMJ: op2 = imm_j;
            OP2_IMU: op2 = imm_u;
            default: op2 = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            issue.pc       <= dec_fetch.pc;
            issue.inst_id  <= dec_fetch.inst_id;
            issue.ctrl     <= ctrl;
            issue.op1      <= op1;
            issue.op2      <= op2;
            issue.rs2_data <= src2;
        end
    end

endmodule

//--- src/decode_unit.sv
/*
 * decode and operand-issue top level
 * fetch input register, decoder, register file, operand stage
 */
`timescale 1ns/100ps

module decode_unit
    import core_pkg::*;
#(
    parameter bit FORWARD = 1'b1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  fetch_t   fetch,
    input  logic     wb_en,
    input  reg_idx_t wb_addr,
    input  xlen_t    wb_data,
    output logic     issue_valid,
    output issue_t   issue
);

    logic     dec_valid;
    fetch_t   dec_fetch;
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rdata1;
    xlen_t    rdata2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec_fetch <= fetch;
        end
    end

    inst_decoder u_dec (
        .inst (dec_fetch.inst),
        .ctrl (ctrl),
        .rs1  (rs1),
        .rs2  (rs2)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rs1),
        .rdata1 (rdata1),
        .raddr2 (rs2),
        .rdata2 (rdata2),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    operand_stage #(
        .FORWARD (FORWARD)
    ) u_ops (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_fetch   (dec_fetch),
        .ctrl        (ctrl),
        .rs1         (rs1),
        .rs2         (rs2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

//--- verification/decode_model.sv
/*
 * reference model for decode_unit
 * expected control bundle for an instruction word
 * expected operands and issue bundle from source values
 */
package decode_model;

import core_pkg::*;

function automatic ctrl_t ctrl_of(alu_fn_e fn, op1_sel_e o1, op2_sel_e o2, mem_fn_e mem,
                                  logic wen, wb_sel_e wb, csr_cmd_e csr, logic br);
    ctrl_t c;
    c = '0;
    c.alu_fn  = fn;
    c.op1_sel = o1;
    c.op2_sel = o2;
    c.mem_fn  = mem;
    c.rf_wen  = wen;
    c.wb_sel  = wb;
    c.csr_cmd = csr;
    c.br_flg  = br;
    return c;
endfunction

function automatic ctrl_t exp_ctrl(xlen_t w);
    ctrl_t      c;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    csr_cmd_e   cmd;
    alu_fn_e    base_fn [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    alu_fn_e    md_fn [8]   = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                                ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    alu_fn_e    br_fn [8]   = '{ALU_BEQ, ALU_BNE, ALU_ADD, ALU_ADD,
                                ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
    mem_fn_e    ld_mem [8]  = '{MEM_LB, MEM_LH, MEM_LW, MEM_NONE,
                                MEM_LBU, MEM_LHU, MEM_NONE, MEM_NONE};
    wb_sel_e    ld_wb [8]   = '{WB_MEMB, WB_MEMH, WB_MEMW, WB_NONE,
                                WB_MEMBU, WB_MEMHU, WB_NONE, WB_NONE};
    mem_fn_e    st_mem [8]  = '{MEM_SB, MEM_SH, MEM_SW, MEM_NONE,
                                MEM_NONE, MEM_NONE, MEM_NONE, MEM_NONE};
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    c   = ctrl_of(ALU_ADD, OP1_NONE, OP2_NONE, MEM_NONE, 1'b0, WB_NONE, CSR_NONE, 1'b0);
    case (opc)
        7'h03: if (ld_mem[f3] != MEM_NONE)
            c = ctrl_of(ALU_ADD, OP1_RS1, OP2_IMI, ld_mem[f3], 1'b1, ld_wb[f3], CSR_NONE, 1'b0);
        7'h23: if (st_mem[f3] != MEM_NONE)
            c = ctrl_of(ALU_ADD, OP1_RS1, OP2_IMS, st_mem[f3], 1'b0, WB_NONE, CSR_NONE, 1'b0);
        7'h33: begin
            if (f7 == 7'h00)
                c = ctrl_of(base_fn[f3], OP1_RS1, OP2_RS2, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
            else if (f7 == 7'h01)
                c = ctrl_of(md_fn[f3], OP1_RS1, OP2_RS2, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
            else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                c = ctrl_of((f3 == 3'd0) ? ALU_SUB : ALU_SRA, OP1_RS1, OP2_RS2, MEM_NONE,
                            1'b1, WB_ALU, CSR_NONE, 1'b0);
        end
        7'h13: begin
            if (f3 == 3'd5 && f7 == 7'h20)
                c = ctrl_of(ALU_SRA, OP1_RS1, OP2_IMI, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
            else if (!(f3 inside {3'd1, 3'd5}) || f7 == 7'h00)   // shifts need a clean funct7
                c = ctrl_of(base_fn[f3], OP1_RS1, OP2_IMI, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
        end
        7'h63: if (!(f3 inside {3'd2, 3'd3}))
            c = ctrl_of(br_fn[f3], OP1_RS1, OP2_RS2, MEM_NONE, 1'b0, WB_NONE, CSR_NONE, 1'b1);
        7'h6f: c = ctrl_of(ALU_ADD, OP1_PC, OP2_IMJ, MEM_NONE, 1'b1, WB_PC, CSR_NONE, 1'b0);
        7'h67: if (f3 == 3'd0)
            c = ctrl_of(ALU_JALR, OP1_RS1, OP2_IMI, MEM_NONE, 1'b1, WB_PC, CSR_NONE, 1'b0);
        7'h37: c = ctrl_of(ALU_ADD, OP1_NONE, OP2_IMU, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
        7'h17: c = ctrl_of(ALU_ADD, OP1_PC, OP2_IMU, MEM_NONE, 1'b1, WB_ALU, CSR_NONE, 1'b0);
        7'h73: begin
            if (f3[1:0] != 2'b00) begin
                cmd = (f3[1:0] == 2'd1) ? CSR_W : (f3[1:0] == 2'd2) ? CSR_S : CSR_C;
                c = ctrl_of(ALU_COPY1, f3[2] ? OP1_IMZ : OP1_RS1, OP2_NONE, MEM_NONE,
                            1'b1, WB_CSR, cmd, 1'b0);
            end else if (w == 32'h00000073) begin
                c.csr_cmd = CSR_ECALL;
            end else if (w == 32'h10200073) begin
                c.csr_cmd = CSR_SRET;
            end else if (w == 32'h30200073) begin
                c.csr_cmd = CSR_MRET;
            end
        end
        7'h2f: if (w[31:27] == 5'b00001 && f3 == 3'd2)
            c = ctrl_of(ALU_COPY1, OP1_RS1, OP2_NONE, MEM_AMOSWAP, 1'b1, WB_MEMW, CSR_NONE, 1'b0);
        default: ;
    endcase
    c.wb_addr = w[11:7];
    c.jmp_pc  = (opc == 7'h6f);
    c.jmp_reg = (opc == 7'h67) && (f3 == 3'd0);
    c.imm_b   = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    return c;
endfunction

function automatic xlen_t exp_op1(ctrl_t c, xlen_t w, xlen_t pc, xlen_t src1);
    case (c.op1_sel)
        OP1_RS1: return src1;
        OP1_PC:  return pc;
        OP1_IMZ: return {27'b0, w[19:15]};
        default: return '0;
    endcase
endfunction

function automatic xlen_t exp_op2(ctrl_t c, xlen_t w, xlen_t src2);
    case (c.op2_sel)
        OP2_RS2: return src2;
        OP2_IMI: return 32'($signed(w[31:20]));
        OP2_IMS: return 32'($signed({w[31:25], w[11:7]}));
        OP2_IMJ: return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        OP2_IMU: return {w[31:12], 12'h000};
        default: return '0;
    endcase
endfunction

function automatic issue_t exp_issue(fetch_t f, xlen_t src1, xlen_t src2);
    issue_t e;
    e.pc       = f.pc;
    e.inst_id  = f.inst_id;
    e.ctrl     = exp_ctrl(f.inst);
    e.op1      = exp_op1(e.ctrl, f.inst, f.pc, src1);
    e.op2      = exp_op2(e.ctrl, f.inst, src2);
    e.rs2_data = src2;
    return e;
endfunction

endpackage

//--- verification/decode_unit_tb.sv
/*
 * testbench for decode_unit
 * clock, reset, lfsr stimulus and shadow register file
 * compare process on the issue port, per-test report
 */
`timescale 1ns/100ps

module decode_unit_tb
    import core_pkg::*;
    import decode_model::*;
();

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    fetch_t      fetch;
    logic        wb_en;
    reg_idx_t    wb_addr;
    xlen_t       wb_data;
    logic        issue_valid;
    issue_t      issue;

    logic [31:0] lfsr_state;
    logic [31:0] tag_cnt;
    xlen_t       shadow [32];
    issue_t      exp_q [$];
    int          due_q [$];
    logic        rd_valid;      // item in its read cycle
    fetch_t      rd_fetch;
    int          cyc;
    int          checks;
    int          errors;
    logic        timed_out;

    decode_unit dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        b;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) lfsr_state = lfsr_state ^ 32'h80200003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic xlen_t read_src(reg_idx_t idx);
        if (idx == '0) return '0;
        else if (wb_en && wb_addr == idx) return wb_data;   // write at end of read cycle
        else return shadow[idx];
    endfunction

    // random word for one instruction class (13 and up stay raw)
    function automatic xlen_t gen_word(int cls);
        xlen_t      w;
        logic [2:0] ld_f3 [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [2:0] br_f3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [2:0] csr_f3 [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
        xlen_t      sys_w [3]  = '{32'h00000073, 32'h10200073, 32'h30200073};
        w = rand_bits(32);
        case (cls)
            0: begin
                w[6:0] = 7'h03;
                w[14:12] = ld_f3[rand_bits(8) % 5];
            end
            1: begin
                w[6:0] = 7'h23;
                w[14:12] = 3'(rand_bits(8) % 3);
            end
            2: begin
                w[6:0] = 7'h33;
                w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && rand_bits(1) != 0)
                           ? 7'h20 : 7'h00;
            end
            3: begin
                w[6:0] = 7'h13;
                if (w[14:12] == 3'd1) w[31:25] = 7'h00;
                if (w[14:12] == 3'd5) w[31:25] = (rand_bits(1) != 0) ? 7'h20 : 7'h00;
            end
            4: begin
                w[6:0] = 7'h63;
                w[14:12] = br_f3[rand_bits(8) % 6];
            end
            5: w[6:0] = 7'h6f;
            6: begin
                w[6:0] = 7'h67;
                w[14:12] = 3'd0;
            end
            7: w[6:0] = 7'h37;
            8: w[6:0] = 7'h17;
            9: begin
                w[6:0] = 7'h73;
                w[14:12] = csr_f3[rand_bits(8) % 6];
            end
            10: w = sys_w[rand_bits(8) % 3];
            11: begin
                w[6:0] = 7'h33;
                w[31:25] = 7'h01;
            end
            12: begin
                w[6:0] = 7'h2f;
                w[14:12] = 3'd2;
                w[31:27] = 5'b00001;
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic check_field(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // one cycle of inputs 1 ns after the edge
    task automatic drive(logic v, xlen_t w, logic we, reg_idx_t wa, xlen_t wd);
        @(posedge clk);
        #1;
        fetch_valid = v;
        if (v) begin
            fetch.pc      = rand_bits(30) << 2;
            fetch.inst    = w;
            fetch.inst_id = {rand_bits(32), tag_cnt};
            tag_cnt++;
        end
        wb_en   = we;
        wb_addr = wa;
        wb_data = wd;
    endtask

    task automatic drive_rand_wb(logic v, xlen_t w);
        logic we;
        we = rand_bits(1) != 0;
        drive(v, w, we, reg_idx_t'(rand_bits(5)), rand_bits(32));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 16) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout with %0d issues still outstanding", exp_q.size());
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic run_test(int t);
        int       base;
        int       i;
        string    name;
        xlen_t    w;
        reg_idx_t ra;
        reg_idx_t rb;
        xlen_t    odd_w [6] = '{32'h00000000, 32'hffffffff, 32'h00100073,
                                32'h40001033, 32'h00004073, 32'h0000300f};
        base = errors;
        case (t)
            1: begin
                name = "reset idle";
                for (i = 1; i < 32; i++) begin   // fills every register
                    drive(1'b0, '0, 1'b1, reg_idx_t'(i), rand_bits(32));
                    check_field("issue_valid", 64'(issue_valid), 64'h0);
                end
            end
            2: begin
                name = "control decode";
                for (i = 0; i < 84; i++) drive_rand_wb(1'b1, gen_word(i / 6));
                for (i = 0; i < 6; i++) drive_rand_wb(1'b1, odd_w[i]);
            end
            3: begin
                name = "operand select";
                drive(1'b0, '0, 1'b1, '0, 32'hdeadbeef);
                for (i = 0; i < 39; i++) begin
                    w = gen_word(i % 13);
                    if (i % 3 == 0) w[24:15] = '0;            // both sources x0
                    drive(1'b1, w, 1'b1, (i % 2 == 0) ? '0 : reg_idx_t'(rand_bits(5)),
                          rand_bits(32));
                end
            end
            4: begin
                name = "wb forwarding";
                for (i = 0; i < 8; i++) begin
                    ra = reg_idx_t'(rand_bits(5));
                    if (ra == '0) ra = 5'd1;
                    rb = (i == 7) ? ra : reg_idx_t'(rand_bits(5));
                    w = {7'h00, rb, ra, 3'b000, 5'd3, 7'h33};   // add x3, ra, rb
                    drive(1'b1, w, 1'b0, '0, '0);
                    drive(i >= 4, w, 1'b1, (i % 2 == 1) ? ra : rb, rand_bits(32));
                end
            end
            default: begin
                name = "back to back";
                for (i = 0; i < 28; i++) drive_rand_wb(1'b1, gen_word(i % 14));
            end
        endcase
        for (i = 0; i < 2; i++) drive(1'b0, '0, 1'b0, '0, '0);
        wait_drain();
        $display("test %0d %s %0d errors", t, name, errors - base);
    endtask

    // outputs and tb inputs are stable at the falling edge
    always @(negedge clk) begin : compare
        issue_t e;
        int     due;
        xlen_t  s1;
        xlen_t  s2;
        cyc++;
        if (issue_valid === 1'b1) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("issue_valid high in cycle %0d with nothing outstanding", cyc);
                errors++;
            end
            if (exp_q.size() > 0) begin
                e   = exp_q.pop_front();
                due = due_q.pop_front();
                checks++;
                assert (due == cyc) else begin
                    $display("issue %h came in cycle %0d, due in %0d", e.inst_id, cyc, due);
                    errors++;
                end
                check_field("issue.inst_id", issue.inst_id, e.inst_id);
                check_field("issue.pc", 64'(issue.pc), 64'(e.pc));
                check_field("issue.ctrl", 128'(issue.ctrl), 128'(e.ctrl));
                check_field("issue.op1", 64'(issue.op1), 64'(e.op1));
                check_field("issue.op2", 64'(issue.op2), 64'(e.op2));
                check_field("issue.rs2_data", 64'(issue.rs2_data), 64'(e.rs2_data));
            end
        end else begin
            assert (due_q.size() == 0 || due_q[0] != cyc) else begin
                $display("no issue in cycle %0d for tag %h", cyc, exp_q[0].inst_id);
                errors++;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
        if (rd_valid) begin
            s1 = read_src(rd_fetch.inst[19:15]);
            s2 = read_src(rd_fetch.inst[24:20]);
            exp_q.push_back(exp_issue(rd_fetch, s1, s2));
            due_q.push_back(cyc + 1);
        end
        if (wb_en && wb_addr != '0) shadow[wb_addr] = wb_data;
        rd_valid = fetch_valid && rst_n;
        rd_fetch = fetch;
    end

    initial begin
        int t;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        lfsr_state  = 32'hdf5259c3;
        tag_cnt     = '0;
        shadow[0]   = '0;
        rd_valid    = 1'b0;
        rd_fetch    = '0;
        cyc         = 0;
        checks      = 0;
        errors      = 0;
        timed_out   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (t = 1; t <= 5 && !timed_out; t++) run_test(t);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- decode_unit.f
+incdir+include
src/core_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_stage.sv
src/decode_unit.sv
verification/decode_model.sv
verification/decode_unit_tb.sv

//--- Bender.yml
package:
  name: decode_unit

sources:
  - include_dirs:
      - include
    files:
      - src/core_pkg.sv
      - src/inst_decoder.sv
      - src/reg_file.sv
      - src/operand_stage.sv
      - src/decode_unit.sv
  - target: test
    files:
      - verification/decode_model.sv
      - verification/decode_unit_tb.sv
